//--- common/canny_pkg.sv
package canny_pkg;

	// image geometry
	localparam int IMG_DIM    = 20;
	localparam int PIX_W      = 5;
	localparam int TOTAL_PIX  = IMG_DIM * IMG_DIM;
	localparam int LOAD_LANES = 5;

	typedef logic [PIX_W-1:0] pixel_t;

	// raster address into either store
	typedef logic [8:0] pix_index_t;

	// one column of three vertically adjacent pixels
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} column_t;

	// five pixels per load cycle with lane0 first in raster order
	typedef struct packed {
		pixel_t lane0;
		pixel_t lane1;
		pixel_t lane2;
		pixel_t lane3;
		pixel_t lane4;
	} load_word_t;

	typedef enum logic [1:0] {
		PASS_MEDIAN,
		PASS_SOBEL,
		PASS_HYSTER
	} pass_t;

endpackage

//--- frame_buffer/frame_buffer.sv
module frame_buffer
	import canny_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  load_word_t pixels,
	input  logic       load_we,
	input  pix_index_t load_addr,
	input  pix_index_t rd_base,
	output column_t    column,
	input  logic       res_we,
	input  pix_index_t res_addr,
	input  pixel_t     res_pixel,
	input  logic       write_back
);

	// working image and the result store of the running pass
	pixel_t img [TOTAL_PIX];
	pixel_t res [TOTAL_PIX];

	// nearest interior row or column for the border ring
	function automatic int clamp_in(input int v);
		if (v < 1) begin
			return 1;
		end else if (v > IMG_DIM - 2) begin
			return IMG_DIM - 2;
		end else begin
			return v;
		end
	endfunction

	// image store written by the five-lane load or the padded copy of results
	always_ff @(posedge clk) begin
		if (write_back) begin
			// corners fall out of clamping both row and column
			for (int r = 0; r < IMG_DIM; r++) begin
				for (int c = 0; c < IMG_DIM; c++) begin
					img[r * IMG_DIM + c] <= res[clamp_in(r) * IMG_DIM + clamp_in(c)];
				end
			end
		end else if (load_we) begin
			img[load_addr]        <= pixels.lane0;
			img[load_addr + 9'd1] <= pixels.lane1;
			img[load_addr + 9'd2] <= pixels.lane2;
			img[load_addr + 9'd3] <= pixels.lane3;
			img[load_addr + 9'd4] <= pixels.lane4;
		end
	end

	// result pixels of the median and sobel passes
	always_ff @(posedge clk) begin
		if (res_we) begin
			res[res_addr] <= res_pixel;
		end
	end

	// three rows of one column available the cycle after rd_base
	always_ff @(posedge clk) begin
		if (reset) begin
			column <= '0;
		end else begin
			column.top <= img[rd_base];
			column.mid <= img[rd_base + 9'(IMG_DIM)];
			column.bot <= img[rd_base + 9'(2 * IMG_DIM)];
		end
	end

endmodule

//--- source/pass_sequencer.sv
module pass_sequencer
	import canny_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       load_end,
	output logic       load_we,
	output pix_index_t load_addr,
	output pix_index_t rd_base,
	output logic       write_back,
	output logic       row_start,
	output logic       med_valid,
	output logic       sob_valid,
	output logic       hys_valid,
	input  logic       med_done,
	input  logic       sob_done,
	input  pixel_t     med_pixel,
	input  pixel_t     sob_pixel,
	output logic       res_we,
	output pix_index_t res_addr,
	output pixel_t     res_pixel
);

	typedef enum logic [2:0] {
		S_LOAD,
		S_SET,
		S_PREP,
		S_WALK,
		S_WB
	} state_t;

	// bands are indexed by their top row
	localparam int LAST_BAND = IMG_DIM - 2;

	state_t     state;
	state_t     state_next;
	pass_t      pass;
	logic [4:0] band;
	logic [4:0] col;
	logic       rd_issue;
	logic       col_valid_q;
	logic       done_any;

	assign rd_issue = (state == S_WALK) && (col < 5'(IMG_DIM));
	assign done_any = med_done | sob_done;

	always_comb begin
		state_next = state;
		case (state)
			S_LOAD: begin
				if (load_end) begin
					state_next = S_SET;
				end
			end
			S_SET: state_next = S_PREP;
			S_PREP: begin
				if (band == 5'(LAST_BAND)) begin
					state_next = (pass == PASS_HYSTER) ? S_LOAD : S_WB;
				end else begin
					state_next = S_WALK;
				end
			end
			S_WALK: begin
				// all reads issued, read register and window drained
				if (col == 5'(IMG_DIM) && !col_valid_q && !done_any) begin
					state_next = S_PREP;
				end
			end
			S_WB: state_next = S_SET;
			default: state_next = S_LOAD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= S_LOAD;
			pass        <= PASS_MEDIAN;
			band        <= '0;
			col         <= '0;
			col_valid_q <= 1'b0;
			load_addr   <= '0;
			res_addr    <= '0;
		end else begin
			state       <= state_next;
			col_valid_q <= rd_issue;
			if (state == S_LOAD) begin
				load_addr <= load_end ? '0 : load_addr + 9'(LOAD_LANES);
			end
			case (state)
				S_LOAD: begin
					if (load_end) begin
						pass <= PASS_MEDIAN;
					end
				end
				S_SET: band <= '0;
				S_PREP: begin
					col      <= '0;
					// first interior pixel of the band's center row
					res_addr <= 9'((band + 1) * IMG_DIM + 1);
				end
				S_WALK: begin
					if (rd_issue) begin
						col <= col + 5'd1;
					end
					if (res_we) begin
						res_addr <= res_addr + 9'd1;
					end
					if (state_next == S_PREP) begin
						band <= band + 5'd1;
					end
				end
				S_WB: pass <= (pass == PASS_MEDIAN) ? PASS_SOBEL : PASS_HYSTER;
				default: ;
			endcase
		end
	end

	assign load_we    = (state == S_LOAD);
	assign write_back = (state == S_WB);
	assign row_start  = (state == S_PREP);

	// address held at zero when no column is read
	assign rd_base = rd_issue ? 9'(band * IMG_DIM + col) : '0;

	// column strobe follows the registered read by one cycle
	assign med_valid = col_valid_q && (pass == PASS_MEDIAN);
	assign sob_valid = col_valid_q && (pass == PASS_SOBEL);
	assign hys_valid = col_valid_q && (pass == PASS_HYSTER);

	assign res_we    = ((pass == PASS_MEDIAN) && med_done) || ((pass == PASS_SOBEL) && sob_done);
	assign res_pixel = (pass == PASS_SOBEL) ? sob_pixel : med_pixel;

endmodule

//--- source/median3x3.sv
module median3x3
	import canny_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    row_start,
	input  logic    col_valid,
	input  column_t column,
	output pixel_t  pixel,
	output logic    out_valid
);

	// pruned 19-stage exchange network leaving the median in slot 4
	localparam int N_CMP = 19;
	localparam int CMP_LO [N_CMP] = '{1, 4, 7, 0, 3, 6, 1, 4, 7, 0, 5, 4, 3, 1, 2, 4, 4, 6, 4};
	localparam int CMP_HI [N_CMP] = '{2, 5, 8, 1, 4, 7, 2, 5, 8, 3, 8, 7, 6, 4, 5, 7, 2, 4, 2};

	// older columns; the incoming column is the right edge of the window
	column_t    left_col;
	column_t    mid_col;
	logic [1:0] fill;
	pixel_t     median;

	always_comb begin
		pixel_t net [9];
		net = '{left_col.top, left_col.mid, left_col.bot,
			mid_col.top, mid_col.mid, mid_col.bot,
			column.top, column.mid, column.bot};
		for (int k = 0; k < N_CMP; k++) begin
			if (net[CMP_LO[k]] > net[CMP_HI[k]]) begin
				{net[CMP_LO[k]], net[CMP_HI[k]]} = {net[CMP_HI[k]], net[CMP_LO[k]]};
			end
		end
		median = net[4];
	end

	// shift in a column on every accepted strobe
	always_ff @(posedge clk) begin
		if (col_valid) begin
			left_col <= mid_col;
			mid_col  <= column;
		end
		if (col_valid && fill == 2'd2) begin
			pixel <= median;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || row_start) begin
			fill      <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= col_valid && (fill == 2'd2);
			if (col_valid && fill != 2'd2) begin
				fill <= fill + 2'd1;
			end
		end
	end

endmodule

//--- source/sobel_grad.sv
module sobel_grad
	import canny_pkg::*;
#(
	parameter int SOBEL_SHIFT = 2
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    row_start,
	input  logic    col_valid,
	input  column_t column,
	output pixel_t  pixel,
	output logic    out_valid
);

	column_t    left_col;
	column_t    mid_col;
	logic [1:0] fill;
	logic [6:0] gx_abs;
	logic [6:0] gy_abs;
	logic [7:0] mag;
	logic [7:0] scaled;
	pixel_t     grad;

	// 1-2-1 weighted sum of three pixels
	function automatic logic [6:0] weigh(input pixel_t a, input pixel_t b, input pixel_t c);
		return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
	endfunction

	function automatic logic [6:0] abs_diff(input logic [6:0] x, input logic [6:0] y);
		return (x > y) ? x - y : y - x;
	endfunction

	// right minus left, bottom minus top
	assign gx_abs = abs_diff(weigh(column.top, column.mid, column.bot),
		weigh(left_col.top, left_col.mid, left_col.bot));
	assign gy_abs = abs_diff(weigh(left_col.bot, mid_col.bot, column.bot),
		weigh(left_col.top, mid_col.top, column.top));

	assign mag    = {1'b0, gx_abs} + {1'b0, gy_abs};
	assign scaled = mag >> SOBEL_SHIFT;
	assign grad   = (scaled > 8'd31) ? 5'd31 : scaled[4:0];

	always_ff @(posedge clk) begin
		if (col_valid) begin
			left_col <= mid_col;
			mid_col  <= column;
		end
		if (col_valid && fill == 2'd2) begin
			pixel <= grad;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || row_start) begin
			fill      <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= col_valid && (fill == 2'd2);
			if (col_valid && fill != 2'd2) begin
				fill <= fill + 2'd1;
			end
		end
	end

endmodule

//--- source/hyster_window.sv
module hyster_window
	import canny_pkg::*;
#(
	parameter int HIGH_TH = 12,
	parameter int LOW_TH  = 6
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    row_start,
	input  logic    col_valid,
	input  column_t column,
	output logic    edge_out,
	output logic    out_valid
);

	column_t    left_col;
	column_t    mid_col;
	logic [1:0] fill;
	logic       strong_nbr;
	logic       edge_bit;

	// any of the eight neighbors of the center pixel is strong
	assign strong_nbr = (left_col.top >= pixel_t'(HIGH_TH)) || (left_col.mid >= pixel_t'(HIGH_TH))
		|| (left_col.bot >= pixel_t'(HIGH_TH)) || (mid_col.top >= pixel_t'(HIGH_TH))
		|| (mid_col.bot >= pixel_t'(HIGH_TH)) || (column.top >= pixel_t'(HIGH_TH))
		|| (column.mid >= pixel_t'(HIGH_TH)) || (column.bot >= pixel_t'(HIGH_TH));

	// strong center, or weak center touching a strong one
	assign edge_bit = (mid_col.mid >= pixel_t'(HIGH_TH))
		|| ((mid_col.mid >= pixel_t'(LOW_TH)) && strong_nbr);

	always_ff @(posedge clk) begin
		if (col_valid) begin
			left_col <= mid_col;
			mid_col  <= column;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || row_start) begin
			fill      <= '0;
			out_valid <= 1'b0;
			edge_out  <= 1'b0;
		end else begin
			out_valid <= col_valid && (fill == 2'd2);
			edge_out  <= col_valid && (fill == 2'd2) && edge_bit;
			if (col_valid && fill != 2'd2) begin
				fill <= fill + 2'd1;
			end
		end
	end

endmodule

//--- source/edge_chip.sv
module edge_chip
	import canny_pkg::*;
#(
	parameter int HIGH_TH     = 12,
	parameter int LOW_TH      = 6,
	parameter int SOBEL_SHIFT = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  load_word_t pixels,
	input  logic       load_end,
	output logic       edge_out,
	output logic       readable
);

	logic       load_we;
	pix_index_t load_addr;
	pix_index_t rd_base;
	column_t    column;
	logic       res_we;
	pix_index_t res_addr;
	pixel_t     res_pixel;
	logic       write_back;
	logic       row_start;
	logic       med_valid;
	logic       sob_valid;
	logic       hys_valid;
	logic       med_done;
	logic       sob_done;
	pixel_t     med_pixel;
	pixel_t     sob_pixel;

	frame_buffer u_frame_buffer (
		.clk        (clk),
		.reset      (reset),
		.pixels     (pixels),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.rd_base    (rd_base),
		.column     (column),
		.res_we     (res_we),
		.res_addr   (res_addr),
		.res_pixel  (res_pixel),
		.write_back (write_back)
	);

	pass_sequencer u_pass_sequencer (
		.clk        (clk),
		.reset      (reset),
		.load_end   (load_end),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.rd_base    (rd_base),
		.write_back (write_back),
		.row_start  (row_start),
		.med_valid  (med_valid),
		.sob_valid  (sob_valid),
		.hys_valid  (hys_valid),
		.med_done   (med_done),
		.sob_done   (sob_done),
		.med_pixel  (med_pixel),
		.sob_pixel  (sob_pixel),
		.res_we     (res_we),
		.res_addr   (res_addr),
		.res_pixel  (res_pixel)
	);

	median3x3 u_median (
		.clk       (clk),
		.reset     (reset),
		.row_start (row_start),
		.col_valid (med_valid),
		.column    (column),
		.pixel     (med_pixel),
		.out_valid (med_done)
	);

	sobel_grad #(
		.SOBEL_SHIFT (SOBEL_SHIFT)
	) u_sobel (
		.clk       (clk),
		.reset     (reset),
		.row_start (row_start),
		.col_valid (sob_valid),
		.column    (column),
		.pixel     (sob_pixel),
		.out_valid (sob_done)
	);

	// final pass drives the chip pins directly
	hyster_window #(
		.HIGH_TH (HIGH_TH),
		.LOW_TH  (LOW_TH)
	) u_hyster (
		.clk       (clk),
		.reset     (reset),
		.row_start (row_start),
		.col_valid (hys_valid),
		.column    (column),
		.edge_out  (edge_out),
		.out_valid (readable)
	);

endmodule

//--- test/edge_model.svh
`ifndef EDGE_MODEL_SVH
`define EDGE_MODEL_SVH

// thresholds and scaling of a chip built with its default parameters
localparam int M_HIGH  = 12;
localparam int M_LOW   = 6;
localparam int M_SHIFT = 2;

int plane    [IMG_DIM][IMG_DIM];
int pass_out [IMG_DIM][IMG_DIM];
bit expect_q [$];

// nearest interior row or column of a border row or column
function automatic int inner_of(input int v);
	if (v == 0) begin
		return 1;
	end
	if (v == IMG_DIM - 1) begin
		return IMG_DIM - 2;
	end
	return v;
endfunction

// pass results back into the image with the border ring replicated
task automatic pad_plane();
	for (int r = 0; r < IMG_DIM; r++) begin
		for (int c = 0; c < IMG_DIM; c++) begin
			plane[r][c] = pass_out[inner_of(r)][inner_of(c)];
		end
	end
endtask

function automatic int median_at(input int r, input int c);
	int v [$];
	for (int dr = -1; dr <= 1; dr++) begin
		for (int dc = -1; dc <= 1; dc++) begin
			v.push_back(plane[r + dr][c + dc]);
		end
	end
	v.sort();
	return v[4];
endfunction

function automatic int sobel_at(input int r, input int c);
	int gx;
	int gy;
	int mag;
	gx = plane[r - 1][c + 1] + 2 * plane[r][c + 1] + plane[r + 1][c + 1]
		- plane[r - 1][c - 1] - 2 * plane[r][c - 1] - plane[r + 1][c - 1];
	gy = plane[r + 1][c - 1] + 2 * plane[r + 1][c] + plane[r + 1][c + 1]
		- plane[r - 1][c - 1] - 2 * plane[r - 1][c] - plane[r - 1][c + 1];
	mag = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
	mag = mag >> M_SHIFT;
	return (mag > 31) ? 31 : mag;
endfunction

function automatic bit hyst_at(input int r, input int c);
	bit strong_nbr;
	strong_nbr = 1'b0;
	for (int dr = -1; dr <= 1; dr++) begin
		for (int dc = -1; dc <= 1; dc++) begin
			if ((dr != 0 || dc != 0) && plane[r + dr][c + dc] >= M_HIGH) begin
				strong_nbr = 1'b1;
			end
		end
	end
	return (plane[r][c] >= M_HIGH) || (plane[r][c] >= M_LOW && strong_nbr);
endfunction

// median, pad, sobel, pad, then queue the hysteresis bits in raster order
task automatic predict(input pixel_t src [TOTAL_PIX]);
	for (int i = 0; i < TOTAL_PIX; i++) begin
		plane[i / IMG_DIM][i % IMG_DIM] = src[i];
	end
	for (int r = 1; r < IMG_DIM - 1; r++) begin
		for (int c = 1; c < IMG_DIM - 1; c++) begin
			pass_out[r][c] = median_at(r, c);
		end
	end
	pad_plane();
	for (int r = 1; r < IMG_DIM - 1; r++) begin
		for (int c = 1; c < IMG_DIM - 1; c++) begin
			pass_out[r][c] = sobel_at(r, c);
		end
	end
	pad_plane();
	for (int r = 1; r < IMG_DIM - 1; r++) begin
		for (int c = 1; c < IMG_DIM - 1; c++) begin
			expect_q.push_back(hyst_at(r, c));
		end
	end
endtask

`endif

//--- test/edge_chip_tb.sv
module edge_chip_tb
	import canny_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_FRAMES = 5;
	localparam int INNER    = IMG_DIM - 2;
	localparam int N_RESULT = INNER * INNER;

	logic       clk;
	logic       reset;
	load_word_t pixels;
	logic       load_end;
	logic       edge_out;
	logic       readable;

	pixel_t frame_in [TOTAL_PIX];
	integer seed;
	int     errors;
	int     tests;
	int     failed;
	int     got;
	int     ones_seen;
	bit     loading;

	`include "edge_model.svh"

	edge_chip UUT (
		.clk      (clk),
		.reset    (reset),
		.pixels   (pixels),
		.load_end (load_end),
		.edge_out (edge_out),
		.readable (readable)
	);

	always #4 clk = ~clk;

	// registered outputs are sampled on the falling edge
	always @(negedge clk) begin
		int idx;
		bit want;
		assert (readable === 1'b1 || edge_out !== 1'b1) else begin
			$display("edge_out went high outside a readable cycle");
			errors++;
		end
		if (readable === 1'b1) begin
			assert (!loading) else begin
				$display("readable pulse while a frame was loading");
				errors++;
			end
			assert (expect_q.size() > 0) else begin
				$display("readable pulse beyond the results of a frame");
				errors++;
			end
			if (expect_q.size() > 0) begin
				want = expect_q.pop_front();
				idx  = (1 + got / INNER) * IMG_DIM + 1 + got % INNER;
				assert (edge_out === want) else begin
					$display("ERR edge_out=%h expected=%h pixel=%h", edge_out, want, idx);
					errors++;
				end
				got++;
				ones_seen += (edge_out === 1'b1) ? 1 : 0;
			end
		end
	end

	// 0 flat, 1 vertical step, 2 impulses, otherwise random
	task automatic make_frame(input int kind);
		int r;
		int c;
		for (int i = 0; i < TOTAL_PIX; i++) begin
			r = i / IMG_DIM;
			c = i % IMG_DIM;
			case (kind)
				0: frame_in[i] = 5'd9;
				1: frame_in[i] = (c < 10) ? 5'd2 : 5'd30;
				2: frame_in[i] = (r % 4 == 2 && c % 4 == 2) ? 5'd31 : 5'd9;
				default: frame_in[i] = pixel_t'($random(seed));
			endcase
		end
	endtask

	// first word goes out on the edge the task is called at
	task automatic load_frame();
		load_word_t word;
		loading = 1'b1;
		for (int w = 0; w < TOTAL_PIX / LOAD_LANES; w++) begin
			if (w > 0) begin
				@(posedge clk);
			end
			word.lane0 = frame_in[w * LOAD_LANES];
			word.lane1 = frame_in[w * LOAD_LANES + 1];
			word.lane2 = frame_in[w * LOAD_LANES + 2];
			word.lane3 = frame_in[w * LOAD_LANES + 3];
			word.lane4 = frame_in[w * LOAD_LANES + 4];
			pixels   <= word;
			load_end <= (w == TOTAL_PIX / LOAD_LANES - 1);
		end
		@(posedge clk);
		load_end <= 1'b0;
		loading = 1'b0;
	endtask

	task automatic run_test(input string name, input int kind, input bit expect_none);
		int err_before;
		err_before = errors;
		make_frame(kind);
		predict(frame_in);
		got       = 0;
		ones_seen = 0;
		load_frame();
		wait (got == N_RESULT);
		if (expect_none) begin
			assert (ones_seen == 0) else begin
				$display("%s produced %0d edge pixels where none belong", name, ones_seen);
				errors++;
			end
		end
		// one prepare cycle before the chip is back in its load state
		@(posedge clk);
		@(posedge clk);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: ok, %0d results, %0d edges", tests, name, got, ones_seen);
		end else begin
			failed++;
			$display("test %0d %s: FAILED, %0d errors", tests, name, errors - err_before);
		end
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		pixels    = '0;
		load_end  = 1'b0;
		seed      = 2;
		errors    = 0;
		tests     = 0;
		failed    = 0;
		got       = 0;
		ones_seen = 0;
		loading   = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		run_test("flat image", 0, 1'b1);
		run_test("vertical step", 1, 1'b0);
		run_test("isolated impulses", 2, 1'b1);
		run_test("random image", 3, 1'b0);
		run_test("back-to-back random image", 3, 1'b0);
		// idle chip in its load state gives no more results
		loading = 1'b1;
		repeat (40) @(posedge clk);
		$display("summary: %0d tests, %0d failing, %0d errors", tests, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog of about 2000 cycles per frame
	initial begin
		#(N_FRAMES * 2000 * 8);
		$display("timeout: the frames did not finish in time, %0d results seen", got);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- edge_chip.f
+incdir+test
common/canny_pkg.sv
frame_buffer/frame_buffer.sv
source/pass_sequencer.sv
source/median3x3.sv
source/sobel_grad.sv
source/hyster_window.sv
source/edge_chip.sv
test/edge_chip_tb.sv

//--- build.sh
#!/usr/bin/env bash
# Compile and run the edge_chip testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=edge_chip_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f edge_chip.f --top-module edge_chip_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "build: Verilator compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ $status -ne 0 ]; then
	echo "build: simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	echo "build: PASS"
	exit 0
else
	echo "build: FAIL"
	exit 1
fi
